//--- src/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 field for the ALU groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BNE     = 3'b001; // beq is 3'b000

  localparam logic [31:0] RESET_PC = 32'h0000_0000; // first fetch address
  localparam int RAM_AW = 10; // word address bits
  localparam int RAM_WORDS = 1 << RAM_AW;

  typedef enum logic [2:0] {
    CLS_R,
    CLS_I,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_LUI,
    CLS_JAL,
    CLS_HALT // ecall and anything unknown
  } instr_class_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B // lui
  } alu_op_t;

endpackage

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire         clk,
  input  wire  [4:0]  rs1_idx,
  input  wire  [4:0]  rs2_idx,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  wire         wr_en,
  input  wire  [4:0]  rd_idx,
  input  wire  [31:0] rd_data
);

  logic [31:0] regs [0:31]; // entry 0 never written

  always_ff @(posedge clk) begin
    if (wr_en && (rd_idx != 5'd0)) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // asynchronous reads, x0 forced to zero
  always_comb begin
    rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
    rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];
  end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  wire rv32_pkg::alu_op_t op,
  input  wire  [31:0]            a,
  input  wire  [31:0]            b,
  output logic [31:0]            result,
  output logic                   equal
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // rv32 shifts use 5 bits

  always_comb begin
    case (op)
      rv32_pkg::ALU_ADD:    result = a + b;
      rv32_pkg::ALU_SUB:    result = a - b;
      rv32_pkg::ALU_AND:    result = a & b;
      rv32_pkg::ALU_OR:     result = a | b;
      rv32_pkg::ALU_XOR:    result = a ^ b;
      rv32_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
      rv32_pkg::ALU_SLTU:   result = {31'd0, a < b};
      rv32_pkg::ALU_SLL:    result = a << shamt;
      rv32_pkg::ALU_SRL:    result = a >> shamt;
      rv32_pkg::ALU_SRA:    result = $signed(a) >>> shamt; // sign fill
      rv32_pkg::ALU_PASS_B: result = b;
      default:              result = a + b;
    endcase
  end

  assign equal = (a == b); // beq / bne

endmodule

`default_nettype wire

//--- src/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  wire  [31:0]                instr,
  output rv32_pkg::instr_class_t     cls,
  output rv32_pkg::alu_op_t          alu_op,
  output logic [4:0]                 rs1_idx,
  output logic [4:0]                 rs2_idx,
  output logic [4:0]                 rd_idx,
  output logic [31:0]                imm,
  output logic                       use_imm,
  output logic                       branch_ne
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;

  // reg_form enables sub; sra/srai always come from bit 30
  function automatic rv32_pkg::alu_op_t funct3_op(input logic [2:0] f3, input logic alt,
                                                  input logic reg_form);
    rv32_pkg::alu_op_t op;
    case (f3)
      rv32_pkg::F3_ADD_SUB: op = (alt && reg_form) ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
      rv32_pkg::F3_SLL:     op = rv32_pkg::ALU_SLL;
      rv32_pkg::F3_SLT:     op = rv32_pkg::ALU_SLT;
      rv32_pkg::F3_SLTU:    op = rv32_pkg::ALU_SLTU;
      rv32_pkg::F3_XOR:     op = rv32_pkg::ALU_XOR;
      rv32_pkg::F3_SRL_SRA: op = alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
      rv32_pkg::F3_OR:      op = rv32_pkg::ALU_OR;
      rv32_pkg::F3_AND:     op = rv32_pkg::ALU_AND;
      default:              op = rv32_pkg::ALU_ADD;
    endcase
    return op;
  endfunction

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign rd_idx  = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};

  assign branch_ne = (funct3 == rv32_pkg::F3_BNE);

  always_comb begin
    cls     = rv32_pkg::CLS_HALT;
    alu_op  = rv32_pkg::ALU_ADD; // address calc for lw/sw
    use_imm = 1'b1;
    imm     = imm_i;
    case (opcode)
      rv32_pkg::OPC_OP: begin
        cls     = rv32_pkg::CLS_R;
        alu_op  = funct3_op(funct3, instr[30], 1'b1);
        use_imm = 1'b0;
      end
      rv32_pkg::OPC_OP_IMM: begin
        cls    = rv32_pkg::CLS_I;
        alu_op = funct3_op(funct3, instr[30], 1'b0);
      end
      rv32_pkg::OPC_LOAD:  cls = rv32_pkg::CLS_LOAD;
      rv32_pkg::OPC_STORE: begin
        cls = rv32_pkg::CLS_STORE;
        imm = imm_s;
      end
      rv32_pkg::OPC_BRANCH: begin
        cls     = rv32_pkg::CLS_BRANCH;
        alu_op  = rv32_pkg::ALU_SUB;
        use_imm = 1'b0; // compare rs1 with rs2
        imm     = imm_b;
      end
      rv32_pkg::OPC_LUI: begin
        cls    = rv32_pkg::CLS_LUI;
        alu_op = rv32_pkg::ALU_PASS_B;
        imm    = imm_u;
      end
      rv32_pkg::OPC_JAL: begin
        cls = rv32_pkg::CLS_JAL;
        imm = imm_j;
      end
      rv32_pkg::OPC_SYSTEM: cls = rv32_pkg::CLS_HALT; // ecall stops the core
      default:              cls = rv32_pkg::CLS_HALT;
    endcase
  end

endmodule

`default_nettype wire

//--- src/multicycle_core.sv
`timescale 1ns/100ps
`default_nettype none

module multicycle_core (
  input  wire         clk,
  input  wire         rst,
  input  wire         ena,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wr_data,
  output logic        mem_wr_en,
  input  wire  [31:0] mem_rd_data,
  output logic [31:0] pc,
  output logic        retired,
  output logic        halted
);

  typedef enum logic [3:0] {
    FETCH,
    FETCH_WAIT,
    DECODE,
    EXECUTE,
    WRITEBACK,
    MEM_ADDR,
    MEM_WAIT,
    MEM_WRITE,
    BRANCH_RESOLVE,
    HALTED
  } state_t;

  state_t state;

  logic [31:0] instr; // instruction register
  logic [31:0] opa_q, opb_q, rs2_q; // operands latched in decode
  logic [31:0] result_q, load_q;
  rv32_pkg::alu_op_t alu_op_q;
  logic [31:0] reg_valid; // registers written since reset

  rv32_pkg::instr_class_t cls;
  rv32_pkg::alu_op_t dec_alu_op;
  logic [4:0]  rs1_idx, rs2_idx, rd_idx;
  logic [31:0] imm;
  logic        use_imm, branch_ne;
  logic [31:0] rs1_raw, rs2_raw, rs1_val, rs2_val;
  logic [31:0] alu_result;
  logic        alu_equal;
  logic [31:0] pc_plus4, pc_target, wb_data;
  logic        wb_en, taken;

  instr_decoder u_decoder (
    .instr     (instr),
    .cls       (cls),
    .alu_op    (dec_alu_op),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd_idx    (rd_idx),
    .imm       (imm),
    .use_imm   (use_imm),
    .branch_ne (branch_ne)
  );

  reg_file u_regs (
    .clk      (clk),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_raw),
    .rs2_data (rs2_raw),
    .wr_en    (wb_en),
    .rd_idx   (rd_idx),
    .rd_data  (wb_data)
  );

  alu u_alu (
    .op     (alu_op_q),
    .a      (opa_q),
    .b      (opb_q),
    .result (alu_result),
    .equal  (alu_equal)
  );

  // unwritten registers read as zero after reset
  assign rs1_val = reg_valid[rs1_idx] ? rs1_raw : 32'd0;
  assign rs2_val = reg_valid[rs2_idx] ? rs2_raw : 32'd0;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm; // branch and jal target
  assign taken     = alu_equal ^ branch_ne;

  always_comb begin
    case (cls)
      rv32_pkg::CLS_LOAD: wb_data = load_q;
      rv32_pkg::CLS_JAL:  wb_data = pc_plus4; // link address
      default:            wb_data = result_q;
    endcase
  end

  // data address held through the wait state so a stall keeps rd_data valid
  assign mem_addr = (state == MEM_ADDR || state == MEM_WAIT || state == MEM_WRITE) ?
                    result_q : pc;
  assign mem_wr_data = rs2_q;
  assign mem_wr_en   = ena && (state == MEM_WRITE);
  assign wb_en       = ena && (state == WRITEBACK);

  assign retired = ena && (state == WRITEBACK || state == MEM_WRITE ||
                           state == BRANCH_RESOLVE || (state == HALTED && !halted));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= FETCH;
      pc        <= rv32_pkg::RESET_PC;
      halted    <= 1'b0;
      reg_valid <= 32'd0;
    end else if (ena) begin
      case (state)
        FETCH:      state <= FETCH_WAIT;
        FETCH_WAIT: state <= DECODE;
        DECODE:     state <= EXECUTE;
        EXECUTE: begin
          case (cls)
            rv32_pkg::CLS_LOAD:   state <= MEM_ADDR;
            rv32_pkg::CLS_STORE:  state <= MEM_WRITE;
            rv32_pkg::CLS_BRANCH: state <= BRANCH_RESOLVE;
            rv32_pkg::CLS_HALT:   state <= HALTED;
            default:              state <= WRITEBACK; // r, i, lui, jal
          endcase
        end
        MEM_ADDR: state <= MEM_WAIT;
        MEM_WAIT: state <= WRITEBACK;
        WRITEBACK: begin
          pc                <= (cls == rv32_pkg::CLS_JAL) ? pc_target : pc_plus4;
          reg_valid[rd_idx] <= 1'b1;
          state             <= FETCH;
        end
        MEM_WRITE: begin
          pc    <= pc_plus4;
          state <= FETCH;
        end
        BRANCH_RESOLVE: begin
          pc    <= taken ? pc_target : pc_plus4;
          state <= FETCH;
        end
        HALTED:  halted <= 1'b1; // stays here until reset
        default: state <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ena) begin
      if (state == FETCH_WAIT) begin
        instr <= mem_rd_data;
      end
      if (state == DECODE) begin
        opa_q    <= rs1_val;
        rs2_q    <= rs2_val; // store data
        opb_q    <= use_imm ? imm : rs2_val;
        alu_op_q <= dec_alu_op;
      end
      if (state == EXECUTE) begin
        result_q <= alu_result;
      end
      if (state == MEM_WAIT) begin
        load_q <= mem_rd_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/unified_ram.sv
`timescale 1ns/100ps
`default_nettype none

module unified_ram (
  input  wire                          clk,
  input  wire  [rv32_pkg::RAM_AW-1:0]  core_addr,
  input  wire  [31:0]                  core_wr_data,
  input  wire                          core_wr_en,
  output logic [31:0]                  core_rd_data,
  input  wire  [rv32_pkg::RAM_AW-1:0]  host_addr,
  input  wire  [31:0]                  host_wr_data,
  input  wire                          host_wr_en,
  output logic [31:0]                  host_rd_data
);

  logic [31:0] mem [0:rv32_pkg::RAM_WORDS-1];
  logic        host_blocked;

  // same word written by both ports, core takes it
  assign host_blocked = core_wr_en && (core_addr == host_addr);

  always_ff @(posedge clk) begin
    if (core_wr_en) begin
      mem[core_addr] <= core_wr_data;
    end
    if (host_wr_en && !host_blocked) begin
      mem[host_addr] <= host_wr_data;
    end
  end

  // registered reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    core_rd_data <= mem[core_addr];
    host_rd_data <= mem[host_addr];
  end

endmodule

`default_nettype wire

//--- src/rv32_system.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_system (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          ena,
  input  wire  [rv32_pkg::RAM_AW-1:0]  host_addr,
  input  wire  [31:0]                  host_wr_data,
  input  wire                          host_wr_en,
  output wire  [31:0]                  host_rd_data,
  output wire  [31:0]                  pc,
  output wire                          retired,
  output wire                          halted
);

  wire [31:0]                 mem_addr;
  wire [31:0]                 mem_wr_data;
  wire [31:0]                 mem_rd_data;
  wire                        mem_wr_en;
  wire [rv32_pkg::RAM_AW-1:0] core_word_addr;

  assign core_word_addr = mem_addr[rv32_pkg::RAM_AW+1:2]; // byte to word address

  multicycle_core u_core (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_en   (mem_wr_en),
    .mem_rd_data (mem_rd_data),
    .pc          (pc),
    .retired     (retired),
    .halted      (halted)
  );

  unified_ram u_ram (
    .clk          (clk),
    .core_addr    (core_word_addr),
    .core_wr_data (mem_wr_data),
    .core_wr_en   (mem_wr_en),
    .core_rd_data (mem_rd_data),
    .host_addr    (host_addr),
    .host_wr_data (host_wr_data),
    .host_wr_en   (host_wr_en),
    .host_rd_data (host_rd_data)
  );

endmodule

`default_nettype wire

//--- bench/core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module core_properties (
  input wire clk,
  input wire rst,
  input wire retired,
  input wire halted,
  input wire mem_wr_en
);

  // one completion per instruction
  retired_single: assert property (@(posedge clk) disable iff (rst) retired |=> !retired)
    else $error("retired stayed high for two cycles");

  no_write_halted: assert property (@(posedge clk) halted |-> !mem_wr_en)
    else $error("memory write while halted");

  // only reset leaves the halted state
  halt_sticky: assert property (@(posedge clk) $fell(halted) |-> $past(rst))
    else $error("halted dropped without reset");

endmodule

bind multicycle_core core_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .retired   (retired),
  .halted    (halted),
  .mem_wr_en (mem_wr_en)
);

`default_nettype wire

//--- bench/rv32_system_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_system_tb;

  typedef struct packed {
    logic        imm_form;
    logic [2:0]  f3;
    logic        alt; // sub / sra select
    logic [31:0] a;
    logic [31:0] b; // already reduced to what the i-form encodes
    logic [31:0] expected;
  } row_t;

  logic                        clk;
  logic                        rst;
  logic                        ena;
  logic [rv32_pkg::RAM_AW-1:0] host_addr;
  logic [31:0]                 host_wr_data;
  logic                        host_wr_en;
  wire  [31:0]                 host_rd_data;
  wire  [31:0]                 pc;
  wire                         retired;
  wire                         halted;

  row_t rows[$];
  int   errors;
  int   seed;

  rv32_system dut (
    .clk          (clk),
    .rst          (rst),
    .ena          (ena),
    .host_addr    (host_addr),
    .host_wr_data (host_wr_data),
    .host_wr_en   (host_wr_en),
    .host_rd_data (host_rd_data),
    .pc           (pc),
    .retired      (retired),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // rv32i semantics for the alu groups
  function automatic logic [31:0] model_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [63:0] wide;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b}; // signs differ
      3'b011: r = {31'd0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        wide = {{32{a[31] & alt}}, a} >> b[4:0]; // upper half carries the fill
        r    = wide[31:0];
      end
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] marker(input logic [rv32_pkg::RAM_AW-1:0] addr);
    return {16'hdead, 6'd0, addr};
  endfunction

  function automatic logic [31:0] r_word(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv32_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], rv32_pkg::OPC_STORE}; // base x0
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] hi);
    return {hi, rd, rv32_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv32_pkg::OPC_JAL};
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    errors++;
  endtask

  task automatic add_row(input logic imm_form, input logic [2:0] f3, input logic alt,
                         input logic [31:0] a, input logic [31:0] b);
    row_t row;
    logic [31:0] b_eff;
    b_eff = b;
    if (imm_form) begin
      b_eff = (f3 == 3'b001 || f3 == 3'b101) ? {27'd0, b[4:0]} : {{20{b[11]}}, b[11:0]};
    end
    row.imm_form = imm_form;
    row.f3       = f3;
    row.alt      = alt;
    row.a        = a;
    row.b        = b_eff;
    row.expected = model_op(f3, alt, a, b_eff);
    rows.push_back(row);
  endtask

  task automatic build_table();
    int k;
    logic [31:0] pick;
    logic [2:0]  f3;
    add_row(1'b0, 3'b000, 1'b0, 32'h7fff_ffff, 32'h0000_0001); // signed overflow
    add_row(1'b0, 3'b000, 1'b1, 32'h0000_0000, 32'h0000_0001); // sub wraps
    add_row(1'b0, 3'b111, 1'b0, 32'hf0f0_a5a5, 32'h0ff0_ffff);
    add_row(1'b0, 3'b110, 1'b0, 32'hf000_0000, 32'h0000_000f);
    add_row(1'b0, 3'b100, 1'b0, 32'haaaa_5555, 32'hffff_0000);
    add_row(1'b0, 3'b010, 1'b0, 32'hffff_fffe, 32'h0000_0001); // -2 < 1
    add_row(1'b0, 3'b011, 1'b0, 32'hffff_fffe, 32'h0000_0001); // big unsigned
    add_row(1'b0, 3'b001, 1'b0, 32'h0000_0001, 32'h0000_003f); // only 5 shift bits count
    add_row(1'b0, 3'b101, 1'b0, 32'h8000_0000, 32'h0000_001f);
    add_row(1'b0, 3'b101, 1'b1, 32'h8000_0000, 32'h0000_001f); // sign fill
    add_row(1'b1, 3'b000, 1'b0, 32'h0000_0010, 32'h0000_0800); // addi -2048
    add_row(1'b1, 3'b111, 1'b0, 32'h1234_5678, 32'h0000_0f0f);
    add_row(1'b1, 3'b110, 1'b0, 32'h1234_5678, 32'h0000_0fff);
    add_row(1'b1, 3'b100, 1'b0, 32'h1234_5678, 32'h0000_0fff); // xori -1 inverts
    add_row(1'b1, 3'b010, 1'b0, 32'h8000_0000, 32'h0000_0000);
    add_row(1'b1, 3'b001, 1'b0, 32'h0000_0003, 32'h0000_001f);
    add_row(1'b1, 3'b101, 1'b0, 32'hf000_0000, 32'h0000_0004);
    add_row(1'b1, 3'b101, 1'b1, 32'hf000_0000, 32'h0000_0004);
    for (k = 0; k < 6; k++) begin
      pick = $random(seed);
      f3   = pick[2:0];
      // no subtract in the immediate group
      add_row(pick[4], f3, pick[3] && (f3 == 3'b101 || (f3 == 3'b000 && !pick[4])),
              $random(seed), $random(seed));
    end
  endtask

  task automatic host_write(input logic [rv32_pkg::RAM_AW-1:0] addr, input logic [31:0] data);
    host_addr    = addr;
    host_wr_data = data;
    host_wr_en   = 1'b1;
    @(posedge clk);
    #1;
    host_wr_en = 1'b0;
  endtask

  task automatic host_read(input logic [rv32_pkg::RAM_AW-1:0] addr, output logic [31:0] data);
    host_addr = addr;
    @(posedge clk);
    #1;
    data = host_rd_data; // one cycle read latency
  endtask

  task automatic load_program(input row_t row, input logic use_bne);
    logic [31:0] prog [0:13];
    logic [31:0] hi_a, hi_b;
    logic [11:0] imm;
    int i;
    hi_a = row.a + 32'h800; // addi sign-extends the low part
    hi_b = row.b + 32'h800;
    imm  = (row.f3 == 3'b001 || row.f3 == 3'b101) ? {1'b0, row.alt, 5'd0, row.b[4:0]} :
           row.b[11:0];
    prog[0]  = lui_word(5'd1, hi_a[31:12]);
    prog[1]  = i_word(rv32_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd1, row.a[11:0]);
    prog[2]  = lui_word(5'd2, hi_b[31:12]);
    prog[3]  = i_word(rv32_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd2, row.b[11:0]);
    prog[4]  = row.imm_form ? i_word(rv32_pkg::OPC_OP_IMM, row.f3, 5'd3, 5'd1, imm) :
               r_word(row.f3, row.alt, 5'd3, 5'd1, 5'd2);
    prog[5]  = sw_word(5'd3, 12'h400); // word 0x100
    prog[6]  = i_word(rv32_pkg::OPC_LOAD, 3'b010, 5'd4, 5'd0, 12'h400);
    prog[7]  = sw_word(5'd4, 12'h404);
    prog[8]  = branch_word(use_bne ? 3'b001 : 3'b000, 5'd1, 5'd1, 13'd8);
    prog[9]  = sw_word(5'd0, 12'h40c); // poison, word 0x103
    prog[10] = jal_word(5'd5, 21'd8);
    prog[11] = sw_word(5'd0, 12'h410); // poison, word 0x104
    prog[12] = sw_word(5'd5, 12'h408);
    prog[13] = {25'd0, rv32_pkg::OPC_SYSTEM}; // ecall
    for (i = 0; i < 14; i++) begin
      host_write(10'(i), prog[i]);
    end
    for (i = 0; i < 5; i++) begin
      host_write(10'h100 + 10'(i), marker(10'h100 + 10'(i)));
    end
  endtask

  task automatic run_program(output int n_retired, output logic done);
    int cyc;
    int stall_at;
    int stall_len;
    logic stalled;
    logic [31:0] pc_hold;
    cyc       = 0;
    n_retired = 0;
    done      = 1'b0;
    stalled   = 1'b0;
    pc_hold   = 32'd0;
    stall_at  = 6 + ($unsigned($random(seed)) % 20);
    stall_len = 2 + ($unsigned($random(seed)) % 8);
    rst = 1'b0;
    ena = 1'b1;
    while (!done && cyc < 500) begin
      @(negedge clk);
      if (retired) n_retired++;
      if (stalled && pc !== pc_hold) flag_mismatch("pc during stall", pc, pc_hold);
      done = halted;
      @(posedge clk);
      #1;
      cyc++;
      if (cyc == stall_at) begin
        ena     = 1'b0;
        stalled = 1'b1;
        pc_hold = pc;
      end
      if (cyc == stall_at + stall_len) begin
        ena     = 1'b1;
        stalled = 1'b0;
      end
    end
  endtask

  task automatic run_case(input row_t row, input logic use_bne);
    logic [31:0] w_res, w_copy, w_link, w_skip0, w_skip1, exp_skip0;
    int n_ret;
    int exp_ret;
    logic done;
    rst = 1'b1;
    ena = 1'b0;
    load_program(row, use_bne);
    run_program(n_ret, done);
    ena = 1'b0;
    if (!done) begin
      $display("timeout: core never raised halted (funct3 %0d, imm form %0d)",
               row.f3, row.imm_form);
      errors++;
    end
    host_read(10'h100, w_res);
    host_read(10'h101, w_copy);
    host_read(10'h102, w_link);
    host_read(10'h103, w_skip0);
    host_read(10'h104, w_skip1);
    exp_skip0 = use_bne ? 32'd0 : marker(10'h103); // bne falls through onto the store
    exp_ret   = use_bne ? 13 : 12;
    if (w_res !== row.expected) flag_mismatch("mem[0x100] alu result", w_res, row.expected);
    if (w_copy !== w_res) flag_mismatch("mem[0x101] load copy", w_copy, w_res);
    if (w_skip0 !== exp_skip0) flag_mismatch("mem[0x103] after branch", w_skip0, exp_skip0);
    if (w_skip1 !== marker(10'h104)) flag_mismatch("mem[0x104] after jal", w_skip1,
                                                   marker(10'h104));
    if (w_link !== 32'd44) flag_mismatch("mem[0x102] jal link", w_link, 32'd44); // jal at 0x28
    if (n_ret != exp_ret) flag_mismatch("retired count", n_ret, exp_ret);
  endtask

  initial begin
    seed         = 95;
    errors       = 0;
    rst          = 1'b1;
    ena          = 1'b0;
    host_addr    = '0;
    host_wr_data = 32'd0;
    host_wr_en   = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    foreach (rows[r]) begin
      run_case(rows[r], 1'b0);
    end
    run_case(rows[0], 1'b1); // not-taken branch path
    $display("%0d errors over %0d program runs", errors, rows.size() + 1);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
src/rv32_pkg.sv
src/reg_file.sv
src/alu.sv
src/instr_decoder.sv
src/multicycle_core.sv
src/unified_ram.sv
src/rv32_system.sv
bench/core_properties.sv
bench/rv32_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rv32 system testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module rv32_system_tb -f tb.f -o rv32_sim \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/rv32_sim > sim.log 2>&1 || echo "simulation exited with an error status"
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || { echo "simulation ended before its summary"; exit 1; }
exit 0
